/* cpu_core.f */
hw/cpu_pkg.sv
hw/control_decode.sv
hw/hazard_unit.sv
hw/reg_file.sv
hw/stage_one.sv
hw/stage_two.sv
hw/stage_three.sv
hw/cpu_core.sv
verif/cpu_checker.sv
verif/tb_cpu_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module tb_cpu_core \
		-Mdir obj_dir -o sim_cpu_core -f cpu_core.f
	./obj_dir/sim_cpu_core | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_cpu_core.sv */
module tb_cpu_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] RESET_PC = 16'h0020;   // Program starts at word 16

    logic        clk;
    logic        rst;
    logic [15:0] imem_addr;
    logic [15:0] imem_rdata;
    logic [15:0] dmem_addr;
    logic [15:0] dmem_wdata;
    logic [15:0] dmem_rdata;
    logic        dmem_we;
    logic        wb_valid;
    logic [3:0]  wb_addr;
    logic [15:0] wb_data;
    logic        halted;
    int          err_count;

    logic [15:0] imem [512];
    logic [15:0] dmem [256];
    logic [15:0] dmem_init [256];   // Copied into dmem while reset is high
    int          seed;
    int          failed_tests;

    assign imem_rdata = imem[imem_addr[9:1]];   // Combinational reads
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= dmem_init[i];
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[8:1]] <= dmem_wdata;
        end
    end

    cpu_core #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .wb_valid(wb_valid), .wb_addr(wb_addr),
        .wb_data(wb_data), .halted(halted)
    );

    cpu_checker #(.RESET_PC(RESET_PC)) u_checker (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .halted(halted), .err_count(err_count)
    );

    function automatic int rand_range(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    // Mode 1 ALU/ADDI, 2 adds memory ops, 3 control flow, 4 everything
    function automatic logic [15:0] gen_instr(int mode, int nregs);
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [31:0] r;
        int          kind;
        ra = 4'(rand_range(nregs));
        rb = 4'(rand_range(nregs));
        r  = $random(seed);
        case (mode)
            1: kind = rand_range(2);
            2: kind = rand_range(4);
            3: kind = rand_range(6);
            default: kind = rand_range(8);
        endcase
        if (mode == 3 && kind >= 2)
            kind = kind + 2;   // Skip LW and SW
        case (kind)
            0: return {cpu_pkg::OP_ALU, ra, rb, r[3:0]};        // Unknown funcs add
            1: return {cpu_pkg::OP_ADDI, ra, r[7:0]};
            2: return {cpu_pkg::OP_LW, ra, rb, 4'h0};
            3: return {cpu_pkg::OP_SW, ra, rb, 4'h0};
            4: return {cpu_pkg::OP_BEQ, ra, rb, 1'b0, r[2:0]};  // Forward offsets only
            5: return {cpu_pkg::OP_BNE, ra, rb, 1'b0, r[2:0]};
            6: return {cpu_pkg::OP_J, 9'h000, r[2:0]};
            default: return {4'(7 + rand_range(8)), r[11:0]};  // Unused opcode
        endcase
    endfunction

    task automatic run_test(input int num, input string name, input int mode,
                            input int nregs, input int len);
        int          base;
        int          errs_before;
        int          cycles;
        int          limit;
        logic [31:0] r;
        base  = int'(RESET_PC[9:1]);
        limit = 3 * len + 20;
        for (int i = 0; i < 512; i++) begin
            imem[i] = {4'hF, 3'b000, 9'(i)};   // HALT tagged with its word index
        end
        for (int i = 0; i < 256; i++) begin
            r = $random(seed);
            dmem_init[i] = r[15:0];
        end
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < len - 1; i++) begin
            imem[base + i] = gen_instr(mode, nregs);
        end
        imem[base + len - 1] = 16'hF000;
        if (num == 5)
            imem[base] = {cpu_pkg::OP_SW, 4'd5, 4'd6, 4'h0};   // Reads r5, r6 straight after reset
        repeat (4) @(negedge clk);
        rst = 1'b0;
        errs_before = err_count;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: test %0d did not halt within %0d cycles", num, limit);
                $display("Done: errors found");
                $finish;
            end
        end
        repeat (2) @(negedge clk);   // Drain stages two and three
        if (err_count == errs_before) begin
            $display("Test %0d %s: pass in %0d cycles", num, name, cycles);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, err_count - errs_before);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        seed         = 55;
        failed_tests = 0;
        run_test(1, "alu_imm", 1, 16, 40);
        run_test(2, "load_store", 2, 8, 40);
        run_test(3, "branch_jump", 3, 4, 40);
        run_test(4, "forward_stall", 4, 4, 48);
        run_test(5, "halt_reset", 4, 16, 12);
        $display("Summary: 5 tests, %0d failed, %0d errors", failed_tests, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verif/cpu_checker.sv */
module cpu_checker #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] imem_addr,
    input  logic        wb_valid,
    input  logic [3:0]  wb_addr,
    input  logic [15:0] wb_data,
    input  logic        dmem_we,
    input  logic [15:0] dmem_addr,
    input  logic [15:0] dmem_wdata,
    input  logic        halted,
    output int          err_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] regs [16];     // Model register file
    logic [15:0] mem [256];     // Model data memory indexed by addr[8:1]
    logic [15:0] model_pc;
    int          errors = 0;
    int          halt_cnt;      // Cycles seen with halted high
    bit          final_done;
    bit          after_reset;
    bit          pending;

    assign err_count = errors;

    // Function field codes as the instruction set defines them
    function automatic logic [15:0] alu_model(logic [3:0] func, logic [15:0] a,
                                              logic [15:0] b);
        case (func)
            4'd1: return a - b;
            4'd2: return a & b;
            4'd3: return a | b;
            4'd4: return a ^ b;
            4'd5: return a << b[3:0];
            4'd6: return a >> b[3:0];
            default: return a + b;   // ADD and unknown codes
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Step over branches, jumps and no-ops up to the next writer or HALT
    task automatic skip_to_writer(output bit found);
        logic [15:0] w;
        bit          done;
        int          guard;
        found = 1'b0;
        done  = 1'b0;
        guard = 0;
        while (!done && guard < 1024) begin
            w = tb_cpu_core.imem[model_pc[9:1]];
            guard++;
            case (w[15:12])
                cpu_pkg::OP_ALU, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
                    found = 1'b1;
                    done  = 1'b1;
                end
                cpu_pkg::OP_HALT: done = 1'b1;
                cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                    // Taken when equality matches the opcode sense
                    if ((regs[w[11:8]] == regs[w[7:4]]) == (w[15:12] == cpu_pkg::OP_BEQ))
                        model_pc = model_pc + 16'd2 + {{11{w[3]}}, w[3:0], 1'b0};
                    else
                        model_pc = model_pc + 16'd2;
                end
                cpu_pkg::OP_J: model_pc = model_pc + 16'd2 + {{3{w[11]}}, w[11:0], 1'b0};
                default: model_pc = model_pc + 16'd2;   // Unused opcodes
            endcase
        end
    endtask

    // One write-back or store from the DUT against the next model writer
    task automatic check_event();
        logic [15:0] w;
        logic [15:0] pc;
        logic [15:0] exp;
        bit          found;
        skip_to_writer(found);
        pc = model_pc;
        w  = tb_cpu_core.imem[model_pc[9:1]];
        if (found)
            model_pc = model_pc + 16'd2;
        if (!found) begin
            $display("%0t: write-back or store after the model reached HALT at pc %h", $time, pc);
            errors++;
        end else if (w[15:12] == cpu_pkg::OP_SW) begin
            if (!dmem_we) begin
                $display("%0t: register write where the model expects a store at pc %h",
                         $time, pc);
                errors++;
            end else begin
                compare_field("dmem_addr", regs[w[7:4]], dmem_addr);
                compare_field("dmem_wdata", regs[w[11:8]], dmem_wdata);
            end
            mem[regs[w[7:4]][8:1]] = regs[w[11:8]];
        end else begin
            case (w[15:12])
                cpu_pkg::OP_ALU:  exp = alu_model(w[3:0], regs[w[11:8]], regs[w[7:4]]);
                cpu_pkg::OP_ADDI: exp = regs[w[11:8]] + {{8{w[7]}}, w[7:0]};
                default:          exp = mem[regs[w[7:4]][8:1]];   // LW
            endcase
            if (!wb_valid) begin
                $display("%0t: store where the model expects a register write at pc %h",
                         $time, pc);
                errors++;
            end else begin
                compare_field("wb_addr", {12'h000, w[11:8]}, {12'h000, wb_addr});
                compare_field("wb_data", exp, wb_data);
            end
            regs[w[11:8]] = exp;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] = 16'h0000;
            end
            for (int i = 0; i < 256; i++) begin
                mem[i] = tb_cpu_core.dmem_init[i];   // Same image the testbench loads
            end
            model_pc    = RESET_PC;
            halt_cnt    = 0;
            final_done  = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset && halted !== 1'b0) begin
                $display("ERR %0t halted expected 0 actual %b", $time, halted);
                errors++;
            end
            if (after_reset)
                compare_field("imem_addr", RESET_PC, imem_addr);   // First fetch address
            after_reset = 1'b0;
            if (wb_valid || dmem_we)
                check_event();
            if (halted && halt_cnt < 2)
                halt_cnt++;
            // Pipeline drained so nothing may remain before HALT
            if (halt_cnt == 2 && !final_done) begin
                skip_to_writer(pending);
                if (pending) begin
                    $display("%0t: missing write-back, model still has pc %h before HALT",
                             $time, model_pc);
                    errors++;
                end else begin
                    compare_field("imem_addr", model_pc, imem_addr);   // PC frozen on HALT
                end
                final_done = 1'b1;
            end
        end
    end

endmodule

/* hw/cpu_core.sv */
module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] imem_addr,
    input  logic [15:0] imem_rdata,
    output logic [15:0] dmem_addr,
    output logic [15:0] dmem_wdata,
    output logic        dmem_we,
    input  logic [15:0] dmem_rdata,
    output logic        wb_valid,
    output logic [3:0]  wb_addr,
    output logic [15:0] wb_data,
    output logic        halted
);

    cpu_pkg::alu_op_e s2_alu_op;
    logic        s2_valid, s2_reg_wr, s2_mem_rd, s2_mem_wr;
    logic [15:0] s2_op_a, s2_op_b, s2_store_data, s2_alu_result;
    logic [3:0]  s2_dest;
    logic        s3_valid, s3_reg_wr, s3_mem_rd, s3_mem_wr;
    logic [15:0] s3_result, s3_store_data;
    logic [3:0]  s3_dest;

    // Fetch, decode, register read, branch
    stage_one #(.RESET_PC(RESET_PC)) u_stage_one (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
        .s2_alu_result(s2_alu_result), .halted(halted), .s2_valid(s2_valid),
        .s2_op_a(s2_op_a), .s2_op_b(s2_op_b), .s2_alu_op(s2_alu_op),
        .s2_reg_wr(s2_reg_wr), .s2_mem_rd(s2_mem_rd), .s2_mem_wr(s2_mem_wr),
        .s2_store_data(s2_store_data), .s2_dest(s2_dest)
    );

    // Execute
    stage_two u_stage_two (
        .clk(clk), .rst(rst), .s2_valid(s2_valid), .s2_op_a(s2_op_a), .s2_op_b(s2_op_b),
        .s2_alu_op(s2_alu_op), .s2_reg_wr(s2_reg_wr), .s2_mem_rd(s2_mem_rd),
        .s2_mem_wr(s2_mem_wr), .s2_store_data(s2_store_data), .s2_dest(s2_dest),
        .s2_alu_result(s2_alu_result), .s3_valid(s3_valid), .s3_result(s3_result),
        .s3_reg_wr(s3_reg_wr), .s3_mem_rd(s3_mem_rd), .s3_mem_wr(s3_mem_wr),
        .s3_store_data(s3_store_data), .s3_dest(s3_dest)
    );

    // Memory access and write-back
    stage_three u_stage_three (
        .s3_valid(s3_valid), .s3_result(s3_result), .s3_reg_wr(s3_reg_wr),
        .s3_mem_rd(s3_mem_rd), .s3_mem_wr(s3_mem_wr), .s3_store_data(s3_store_data),
        .s3_dest(s3_dest), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

/* hw/stage_three.sv */
module stage_three (
    input  logic        s3_valid,
    input  logic [15:0] s3_result,
    input  logic        s3_reg_wr,
    input  logic        s3_mem_rd,
    input  logic        s3_mem_wr,
    input  logic [15:0] s3_store_data,
    input  logic [3:0]  s3_dest,
    output logic [15:0] dmem_addr,
    output logic [15:0] dmem_wdata,
    output logic        dmem_we,
    input  logic [15:0] dmem_rdata,
    output logic        wb_valid,
    output logic [3:0]  wb_addr,
    output logic [15:0] wb_data
);

    // Memory port, address is the ALU result of rb + 0
    assign dmem_addr  = s3_result;
    assign dmem_wdata = s3_store_data;
    assign dmem_we    = s3_valid && s3_mem_wr;   // Write lands at the clock edge

    // Write-back select
    assign wb_valid = s3_valid && s3_reg_wr;
    assign wb_addr  = s3_dest;
    assign wb_data  = s3_mem_rd ? dmem_rdata : s3_result;

endmodule

/* hw/stage_two.sv */
module stage_two (
    input  logic             clk,
    input  logic             rst,
    input  logic             s2_valid,
    input  logic [15:0]      s2_op_a,
    input  logic [15:0]      s2_op_b,
    input  cpu_pkg::alu_op_e s2_alu_op,
    input  logic             s2_reg_wr,
    input  logic             s2_mem_rd,
    input  logic             s2_mem_wr,
    input  logic [15:0]      s2_store_data,
    input  logic [3:0]       s2_dest,
    output logic [15:0]      s2_alu_result,
    output logic             s3_valid,
    output logic [15:0]      s3_result,
    output logic             s3_reg_wr,
    output logic             s3_mem_rd,
    output logic             s3_mem_wr,
    output logic [15:0]      s3_store_data,
    output logic [3:0]       s3_dest
);

    // ALU, also feeds the forwarding path in stage one
    always_comb begin
        case (s2_alu_op)
            cpu_pkg::ALU_SUB: s2_alu_result = s2_op_a - s2_op_b;
            cpu_pkg::ALU_AND: s2_alu_result = s2_op_a & s2_op_b;
            cpu_pkg::ALU_OR:  s2_alu_result = s2_op_a | s2_op_b;
            cpu_pkg::ALU_XOR: s2_alu_result = s2_op_a ^ s2_op_b;
            cpu_pkg::ALU_SLL: s2_alu_result = s2_op_a << s2_op_b[3:0];  // Low nibble only
            cpu_pkg::ALU_SRL: s2_alu_result = s2_op_a >> s2_op_b[3:0];
            default:          s2_alu_result = s2_op_a + s2_op_b;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s3_valid  <= 1'b0;
            s3_reg_wr <= 1'b0;
            s3_mem_rd <= 1'b0;
            s3_mem_wr <= 1'b0;
        end else begin
            s3_valid  <= s2_valid;
            s3_reg_wr <= s2_reg_wr;
            s3_mem_rd <= s2_mem_rd;
            s3_mem_wr <= s2_mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        s3_result     <= s2_alu_result;
        s3_store_data <= s2_store_data;
        s3_dest       <= s2_dest;
    end

endmodule

/* hw/stage_one.sv */
module stage_one #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic             clk,
    input  logic             rst,
    output logic [15:0]      imem_addr,
    input  logic [15:0]      imem_rdata,
    input  logic             wb_valid,
    input  logic [3:0]       wb_addr,
    input  logic [15:0]      wb_data,
    input  logic [15:0]      s2_alu_result,
    output logic             halted,
    output logic             s2_valid,
    output logic [15:0]      s2_op_a,
    output logic [15:0]      s2_op_b,
    output cpu_pkg::alu_op_e s2_alu_op,
    output logic             s2_reg_wr,
    output logic             s2_mem_rd,
    output logic             s2_mem_wr,
    output logic [15:0]      s2_store_data,
    output logic [3:0]       s2_dest
);

    cpu_pkg::instr_u   instr;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::fwd_sel_e fwd_a;
    cpu_pkg::fwd_sel_e fwd_b;
    logic        reg_wr, mem_rd, mem_wr, use_imm;
    logic        is_beq, is_bne, is_jump, is_halt;
    logic        uses_ra, uses_rb, stall;
    logic [15:0] pc, pc_plus2, br_target, j_target, next_pc;
    logic [15:0] ra_data, rb_data, ra_val, rb_val, imm_sext;
    logic        take_branch, issue, is_mem;

    assign imem_addr = pc;
    assign instr     = imem_rdata;   // Reinterpreted through the union views

    control_decode u_decode (
        .instr(instr), .alu_op(alu_op), .reg_wr(reg_wr), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .use_imm(use_imm), .is_beq(is_beq), .is_bne(is_bne),
        .is_jump(is_jump), .is_halt(is_halt), .uses_ra(uses_ra), .uses_rb(uses_rb)
    );

    hazard_unit u_hazard (
        .ra(instr.r_fmt.ra), .rb(instr.r_fmt.rb), .uses_ra(uses_ra), .uses_rb(uses_rb),
        .s2_valid(s2_valid), .s2_reg_wr(s2_reg_wr), .s2_mem_rd(s2_mem_rd),
        .s2_dest(s2_dest), .s3_valid(wb_valid),
        .s3_reg_wr(1'b1),             // wb_valid already means a register write
        .s3_dest(wb_addr), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    reg_file u_regs (
        .clk(clk), .rst(rst), .ra_addr(instr.r_fmt.ra), .rb_addr(instr.r_fmt.rb),
        .ra_data(ra_data), .rb_data(rb_data), .wr_en(wb_valid), .wr_addr(wb_addr),
        .wr_data(wb_data)
    );

    // Forwarding muxes
    assign ra_val = (fwd_a == cpu_pkg::FWD_S2) ? s2_alu_result :
                    (fwd_a == cpu_pkg::FWD_S3) ? wb_data : ra_data;
    assign rb_val = (fwd_b == cpu_pkg::FWD_S2) ? s2_alu_result :
                    (fwd_b == cpu_pkg::FWD_S3) ? wb_data : rb_data;

    // Branch resolution in decode, nothing to flush
    assign take_branch = (is_beq && (ra_val == rb_val)) || (is_bne && (ra_val != rb_val));
    assign pc_plus2    = pc + 16'd2;
    assign br_target   = pc_plus2 + {{11{instr.b_fmt.off4[3]}}, instr.b_fmt.off4, 1'b0};
    assign j_target    = pc_plus2 + {{3{instr.j_fmt.off12[11]}}, instr.j_fmt.off12, 1'b0};
    assign next_pc     = is_jump ? j_target : (take_branch ? br_target : pc_plus2);

    assign imm_sext = {{8{instr.i_fmt.imm8[7]}}, instr.i_fmt.imm8};
    assign is_mem   = mem_rd || mem_wr;           // Address is rb + 0
    assign issue    = !stall && !halted && (reg_wr || mem_wr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            if (is_halt) halted <= 1'b1;                    // Sticky until reset
            if (!stall && !halted && !is_halt) pc <= next_pc;
        end
    end

    // Stage-two controls, bubble on stall, halt or non-writing ops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid  <= 1'b0;
            s2_reg_wr <= 1'b0;
            s2_mem_rd <= 1'b0;
            s2_mem_wr <= 1'b0;
        end else begin
            s2_valid  <= issue;
            s2_reg_wr <= issue && reg_wr;
            s2_mem_rd <= issue && mem_rd;
            s2_mem_wr <= issue && mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        s2_op_a       <= is_mem ? rb_val : ra_val;
        s2_op_b       <= use_imm ? imm_sext : (is_mem ? 16'h0000 : rb_val);
        s2_alu_op     <= alu_op;
        s2_store_data <= ra_val;
        s2_dest       <= instr.r_fmt.ra;      // ra doubles as destination
    end

endmodule

/* hw/reg_file.sv */
module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  ra_addr,
    input  logic [3:0]  rb_addr,
    output logic [15:0] ra_data,
    output logic [15:0] rb_data,
    input  logic        wr_en,
    input  logic [3:0]  wr_addr,
    input  logic [15:0] wr_data
);

    logic [15:0] regs [16];

    // Asynchronous reads, old value on same-cycle write
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

    // Single write port, whole file cleared on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* hw/hazard_unit.sv */
module hazard_unit (
    input  logic              [3:0] ra,
    input  logic              [3:0] rb,
    input  logic                    uses_ra,
    input  logic                    uses_rb,
    input  logic                    s2_valid,
    input  logic                    s2_reg_wr,
    input  logic                    s2_mem_rd,
    input  logic              [3:0] s2_dest,
    input  logic                    s3_valid,
    input  logic                    s3_reg_wr,
    input  logic              [3:0] s3_dest,
    output cpu_pkg::fwd_sel_e       fwd_a,
    output cpu_pkg::fwd_sel_e       fwd_b,
    output logic                    stall
);

    logic s2_wr;    // Stage two will write a register
    logic s3_wr;    // Stage three writes this cycle
    logic a_s2_hit;
    logic b_s2_hit;
    logic a_s3_hit;
    logic b_s3_hit;

    assign s2_wr = s2_valid && s2_reg_wr;
    assign s3_wr = s3_valid && s3_reg_wr;

    assign a_s2_hit = uses_ra && s2_wr && (s2_dest == ra);
    assign b_s2_hit = uses_rb && s2_wr && (s2_dest == rb);
    assign a_s3_hit = uses_ra && s3_wr && (s3_dest == ra);
    assign b_s3_hit = uses_rb && s3_wr && (s3_dest == rb);

    // Younger producer wins
    assign fwd_a = a_s2_hit ? cpu_pkg::FWD_S2 :
                   a_s3_hit ? cpu_pkg::FWD_S3 : cpu_pkg::FWD_REG;
    assign fwd_b = b_s2_hit ? cpu_pkg::FWD_S2 :
                   b_s3_hit ? cpu_pkg::FWD_S3 : cpu_pkg::FWD_REG;

    // Load data not ready until stage three, wait one cycle
    assign stall = s2_mem_rd && (a_s2_hit || b_s2_hit);

endmodule

/* hw/control_decode.sv */
module control_decode (
    input  cpu_pkg::instr_u  instr,
    output cpu_pkg::alu_op_e alu_op,
    output logic             reg_wr,
    output logic             mem_rd,
    output logic             mem_wr,
    output logic             use_imm,
    output logic             is_beq,
    output logic             is_bne,
    output logic             is_jump,
    output logic             is_halt,
    output logic             uses_ra,
    output logic             uses_rb
);

    always_comb begin
        // Defaults describe a no-op
        alu_op  = cpu_pkg::ALU_ADD;
        reg_wr  = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        use_imm = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jump = 1'b0;
        is_halt = 1'b0;
        uses_ra = 1'b0;
        uses_rb = 1'b0;
        case (instr.r_fmt.op)
            cpu_pkg::OP_ALU: begin
                reg_wr  = 1'b1;
                uses_ra = 1'b1;
                uses_rb = 1'b1;
                case (instr.r_fmt.func)
                    cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_AND,
                    cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR, cpu_pkg::ALU_SLL,
                    cpu_pkg::ALU_SRL: alu_op = instr.r_fmt.func;
                    default:          alu_op = cpu_pkg::ALU_ADD;  // Unknown func adds
                endcase
            end
            cpu_pkg::OP_ADDI: begin
                reg_wr  = 1'b1;
                use_imm = 1'b1;
                uses_ra = 1'b1;   // ra is source and destination
            end
            cpu_pkg::OP_LW: begin
                reg_wr  = 1'b1;
                mem_rd  = 1'b1;
                uses_rb = 1'b1;   // Address only
            end
            cpu_pkg::OP_SW: begin
                mem_wr  = 1'b1;
                uses_ra = 1'b1;   // Store data
                uses_rb = 1'b1;   // Address
            end
            cpu_pkg::OP_BEQ: begin
                is_beq  = 1'b1;
                uses_ra = 1'b1;
                uses_rb = 1'b1;
            end
            cpu_pkg::OP_BNE: begin
                is_bne  = 1'b1;
                uses_ra = 1'b1;
                uses_rb = 1'b1;
            end
            cpu_pkg::OP_J:    is_jump = 1'b1;
            cpu_pkg::OP_HALT: is_halt = 1'b1;
            default: ;        // No-op
        endcase
    end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    // Top nibble of every instruction
    typedef enum logic [3:0] {
        OP_ALU  = 4'd0,
        OP_ADDI = 4'd1,
        OP_LW   = 4'd2,
        OP_SW   = 4'd3,
        OP_BEQ  = 4'd4,
        OP_BNE  = 4'd5,
        OP_J    = 4'd6,
        OP_HALT = 4'd15   // Remaining codes behave as no-ops
    } opcode_e;

    // ALU operation, same encoding as the OP_ALU function field
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_e;

    // Where a stage-one operand comes from
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,   // Register file
        FWD_S2  = 2'd1,   // Stage-two ALU result
        FWD_S3  = 2'd2    // Stage-three write-back data
    } fwd_sel_e;

    // One 16-bit word, four instruction formats
    typedef union packed {
        struct packed {opcode_e op; logic [3:0] ra; logic [3:0] rb; alu_op_e func;} r_fmt;
        struct packed {opcode_e op; logic [3:0] ra; logic [7:0] imm8;} i_fmt;
        struct packed {opcode_e op; logic [3:0] ra; logic [3:0] rb; logic [3:0] off4;} b_fmt;
        struct packed {opcode_e op; logic [11:0] off12;} j_fmt;
    } instr_u;

endpackage
